//--- trace_cfg_pkg.sv
`default_nettype none

package trace_cfg_pkg;

  // ------------------------------------------------------------------------
  // Datapath widths
  // ------------------------------------------------------------------------
  localparam int unsigned XLEN = 32;
  localparam int unsigned VLEN = 32;  // Virtual address
  localparam int unsigned PLEN = 34;  // Physical address, Sv32

  // Shadow scoreboard sizing
  localparam int unsigned NR_SB_ENTRIES = 8;
  localparam int unsigned TRANS_ID_BITS = 3;
  localparam int unsigned BE_BITS       = XLEN / 8;

  // Fixed fields of the retirement record
  localparam logic [1:0] IXL        = 2'd1;   // 1 means 32-bit ISA
  localparam logic [1:0] MODE_DEBUG = 2'b10;  // Reported mode in debug mode

endpackage

`default_nettype wire

//--- trace_isa_pkg.sv
`default_nettype none

package trace_isa_pkg;

  // Unit class as seen by the LSU probe
  typedef enum logic [1:0] {
    FU_NONE  = 2'd0,
    FU_LOAD  = 2'd1,
    FU_STORE = 2'd2
  } fu_e;

  // Privilege levels, encoding as in mstatus.MPP
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // Synchronous exception causes that the tracer tells apart
  typedef enum logic [4:0] {
    EXC_ILLEGAL_INSTR = 5'd2,
    EXC_BREAKPOINT    = 5'd3,
    EXC_LOAD_FAULT    = 5'd5,
    EXC_ECALL_U       = 5'd8,
    EXC_ECALL_S       = 5'd9,
    EXC_ECALL_M       = 5'd11
  } exc_cause_e;

endpackage

`default_nettype wire

//--- issue_capture.sv
`default_nettype none

module issue_capture (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        fetch_valid_i,
  input  wire logic [31:0] fetch_instr_i,
  input  wire logic        fetch_compressed_i,
  input  wire logic        issue_ack_i,
  input  wire logic        flush_i,
  output logic      [31:0] issue_instr_o
);

  logic        valid_q, valid_n;
  logic [31:0] instr_q, instr_n;

  always_comb begin
    valid_n = valid_q;
    instr_n = instr_q;

    if (issue_ack_i) valid_n = 1'b0;  // Word handed to issue

    // Take a new word only when there is room for it
    if (fetch_valid_i && (!valid_q || issue_ack_i)) begin
      valid_n = 1'b1;
      // Keep the raw 16-bit encoding of a compressed instruction
      instr_n = fetch_compressed_i ? {16'h0000, fetch_instr_i[15:0]} : fetch_instr_i;
    end

    if (flush_i) valid_n = 1'b0;  // Flush wins
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      instr_q <= '0;
    end else begin
      valid_q <= valid_n;
      instr_q <= instr_n;
    end
  end

  assign issue_instr_o = instr_q;

endmodule

`default_nettype wire

//--- trace_scoreboard.sv
`default_nettype none

module trace_scoreboard (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  // Issue probes
  input  wire logic                                  decoded_valid_i,
  input  wire logic                                  decoded_ack_i,
  input  wire logic                                  flush_unissued_i,
  input  wire logic [trace_cfg_pkg::TRANS_ID_BITS-1:0] issue_ptr_i,
  input  wire logic [31:0]                           issue_instr_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]        rs1_fwd_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]        rs2_fwd_i,
  // LSU probes
  input  wire trace_isa_pkg::fu_e                    lsu_fu_i,
  input  wire logic [trace_cfg_pkg::BE_BITS-1:0]     lsu_be_i,
  input  wire logic [trace_cfg_pkg::VLEN-1:0]        lsu_vaddr_i,
  input  wire logic [trace_cfg_pkg::TRANS_ID_BITS-1:0] lsu_trans_id_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]        lsu_wdata_i,
  // Commit side read port
  input  wire logic [trace_cfg_pkg::TRANS_ID_BITS-1:0] commit_ptr_i,
  output logic      [trace_cfg_pkg::XLEN-1:0]        sb_rs1_rdata_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]        sb_rs2_rdata_o,
  output logic      [trace_cfg_pkg::VLEN-1:0]        sb_lsu_addr_o,
  output logic      [trace_cfg_pkg::BE_BITS-1:0]     sb_lsu_rmask_o,
  output logic      [trace_cfg_pkg::BE_BITS-1:0]     sb_lsu_wmask_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]        sb_lsu_wdata_o,
  output logic      [31:0]                           sb_instr_o
);

  import trace_cfg_pkg::*;
  import trace_isa_pkg::*;

  // --------------------------------------------------------------------------
  // Shadow memory, one entry per transaction id
  // --------------------------------------------------------------------------
  logic [XLEN-1:0]    rs1_q   [NR_SB_ENTRIES];
  logic [XLEN-1:0]    rs2_q   [NR_SB_ENTRIES];
  logic [VLEN-1:0]    addr_q  [NR_SB_ENTRIES];
  logic [BE_BITS-1:0] rmask_q [NR_SB_ENTRIES];
  logic [BE_BITS-1:0] wmask_q [NR_SB_ENTRIES];
  logic [XLEN-1:0]    wdata_q [NR_SB_ENTRIES];
  logic [31:0]        instr_q [NR_SB_ENTRIES];

  logic [XLEN-1:0]    rs1_n   [NR_SB_ENTRIES];
  logic [XLEN-1:0]    rs2_n   [NR_SB_ENTRIES];
  logic [VLEN-1:0]    addr_n  [NR_SB_ENTRIES];
  logic [BE_BITS-1:0] rmask_n [NR_SB_ENTRIES];
  logic [BE_BITS-1:0] wmask_n [NR_SB_ENTRIES];
  logic [XLEN-1:0]    wdata_n [NR_SB_ENTRIES];
  logic [31:0]        instr_n [NR_SB_ENTRIES];

  logic [BE_BITS-1:0] lsu_rmask;
  logic [BE_BITS-1:0] lsu_wmask;

  assign lsu_rmask = (lsu_fu_i == FU_LOAD)  ? lsu_be_i : '0;
  assign lsu_wmask = (lsu_fu_i == FU_STORE) ? lsu_be_i : '0;

  always_comb begin
    rs1_n   = rs1_q;
    rs2_n   = rs2_q;
    addr_n  = addr_q;
    rmask_n = rmask_q;
    wmask_n = wmask_q;
    wdata_n = wdata_q;
    instr_n = instr_q;

    // New issue, LSU fields start empty
    if (decoded_valid_i && decoded_ack_i && !flush_unissued_i) begin
      rs1_n[issue_ptr_i]   = rs1_fwd_i;
      rs2_n[issue_ptr_i]   = rs2_fwd_i;
      addr_n[issue_ptr_i]  = '0;
      rmask_n[issue_ptr_i] = '0;
      wmask_n[issue_ptr_i] = '0;
      wdata_n[issue_ptr_i] = '0;
      instr_n[issue_ptr_i] = issue_instr_i;
    end

    // LSU update comes later in the chain, load first
    if (lsu_rmask != '0) begin
      addr_n[lsu_trans_id_i]  = lsu_vaddr_i;
      rmask_n[lsu_trans_id_i] = lsu_rmask;
    end else if (lsu_wmask != '0) begin
      addr_n[lsu_trans_id_i]  = lsu_vaddr_i;
      wmask_n[lsu_trans_id_i] = lsu_wmask;
      wdata_n[lsu_trans_id_i] = lsu_wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NR_SB_ENTRIES; i++) begin
        rs1_q[i]   <= '0;
        rs2_q[i]   <= '0;
        addr_q[i]  <= '0;
        rmask_q[i] <= '0;
        wmask_q[i] <= '0;
        wdata_q[i] <= '0;
        instr_q[i] <= '0;
      end
    end else begin
      rs1_q   <= rs1_n;
      rs2_q   <= rs2_n;
      addr_q  <= addr_n;
      rmask_q <= rmask_n;
      wmask_q <= wmask_n;
      wdata_q <= wdata_n;
      instr_q <= instr_n;
    end
  end

  // Entry of the retiring instruction
  assign sb_rs1_rdata_o = rs1_q[commit_ptr_i];
  assign sb_rs2_rdata_o = rs2_q[commit_ptr_i];
  assign sb_lsu_addr_o  = addr_q[commit_ptr_i];
  assign sb_lsu_rmask_o = rmask_q[commit_ptr_i];
  assign sb_lsu_wmask_o = wmask_q[commit_ptr_i];
  assign sb_lsu_wdata_o = wdata_q[commit_ptr_i];
  assign sb_instr_o     = instr_q[commit_ptr_i];

endmodule

`default_nettype wire

//--- commit_packer.sv
`default_nettype none

module commit_packer (
  input  wire logic                              commit_valid_i,
  input  wire logic                              commit_ack_i,
  input  wire logic                              ex_valid_i,
  input  wire logic                              debug_mode_i,
  input  wire trace_isa_pkg::exc_cause_e         ex_cause_i,
  input  wire trace_isa_pkg::priv_lvl_e          priv_lvl_i,
  input  wire logic [trace_cfg_pkg::VLEN-1:0]    commit_pc_i,
  input  wire logic [4:0]                        commit_rs1_i,
  input  wire logic [4:0]                        commit_rs2_i,
  input  wire logic [4:0]                        commit_rd_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]    commit_result_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]    commit_wdata_i,
  input  wire logic [trace_cfg_pkg::PLEN-1:0]    mem_paddr_i,
  // Scoreboard entry at the commit pointer
  input  wire logic [trace_cfg_pkg::XLEN-1:0]    sb_rs1_rdata_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]    sb_rs2_rdata_i,
  input  wire logic [trace_cfg_pkg::VLEN-1:0]    sb_lsu_addr_i,
  input  wire logic [trace_cfg_pkg::BE_BITS-1:0] sb_lsu_rmask_i,
  input  wire logic [trace_cfg_pkg::BE_BITS-1:0] sb_lsu_wmask_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]    sb_lsu_wdata_i,
  input  wire logic [31:0]                       sb_instr_i,
  // Retirement record
  output logic                                   rvfi_valid_o,
  output logic                                   rvfi_trap_o,
  output logic      [31:0]                       rvfi_insn_o,
  output trace_isa_pkg::exc_cause_e              rvfi_cause_o,
  output logic      [1:0]                        rvfi_mode_o,
  output logic      [1:0]                        rvfi_ixl_o,
  output logic      [4:0]                        rvfi_rs1_addr_o,
  output logic      [4:0]                        rvfi_rs2_addr_o,
  output logic      [4:0]                        rvfi_rd_addr_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]    rvfi_rd_wdata_o,
  output logic      [trace_cfg_pkg::VLEN-1:0]    rvfi_pc_rdata_o,
  output logic      [trace_cfg_pkg::VLEN-1:0]    rvfi_mem_addr_o,
  output logic      [trace_cfg_pkg::PLEN-1:0]    rvfi_mem_paddr_o,
  output logic      [trace_cfg_pkg::BE_BITS-1:0] rvfi_mem_rmask_o,
  output logic      [trace_cfg_pkg::BE_BITS-1:0] rvfi_mem_wmask_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]    rvfi_mem_wdata_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]    rvfi_mem_rdata_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]    rvfi_rs1_rdata_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]    rvfi_rs2_rdata_o
);

  import trace_cfg_pkg::*;
  import trace_isa_pkg::*;

  logic exception;
  logic env_call;

  assign exception = commit_valid_i && ex_valid_i;
  assign env_call  = ex_cause_i inside {EXC_ECALL_U, EXC_ECALL_S, EXC_ECALL_M};

  // An ecall still counts as retired, other traps do not
  assign rvfi_valid_o = (commit_ack_i && !ex_valid_i) || (exception && env_call);
  assign rvfi_trap_o  = exception;
  assign rvfi_cause_o = ex_cause_i;
  assign rvfi_mode_o  = debug_mode_i ? MODE_DEBUG : priv_lvl_i;
  assign rvfi_ixl_o   = IXL;

  assign rvfi_insn_o      = sb_instr_i;
  assign rvfi_rs1_addr_o  = commit_rs1_i;
  assign rvfi_rs2_addr_o  = commit_rs2_i;
  assign rvfi_rd_addr_o   = commit_rd_i;
  assign rvfi_rd_wdata_o  = commit_wdata_i;  // Integer write-back only
  assign rvfi_pc_rdata_o  = commit_pc_i;
  assign rvfi_rs1_rdata_o = sb_rs1_rdata_i;
  assign rvfi_rs2_rdata_o = sb_rs2_rdata_i;

  // Memory side
  assign rvfi_mem_addr_o  = sb_lsu_addr_i;
  assign rvfi_mem_paddr_o = mem_paddr_i;  // Write address only
  assign rvfi_mem_rmask_o = sb_lsu_rmask_i;
  assign rvfi_mem_wmask_o = sb_lsu_wmask_i;
  assign rvfi_mem_wdata_o = sb_lsu_wdata_i;
  assign rvfi_mem_rdata_o = commit_result_i;  // Load data returns as result

endmodule

`default_nettype wire

//--- rvfi_trace.sv
`default_nettype none

module rvfi_trace (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  // Fetch and decode probes
  input  wire logic                                  fetch_valid_i,
  input  wire logic [31:0]                           fetch_instr_i,
  input  wire logic                                  fetch_compressed_i,
  input  wire logic                                  issue_ack_i,
  input  wire logic                                  flush_i,
  // Issue probes
  input  wire logic                                  decoded_valid_i,
  input  wire logic                                  decoded_ack_i,
  input  wire logic                                  flush_unissued_i,
  input  wire logic [trace_cfg_pkg::TRANS_ID_BITS-1:0] issue_ptr_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]        rs1_fwd_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]        rs2_fwd_i,
  // LSU probes
  input  wire trace_isa_pkg::fu_e                    lsu_fu_i,
  input  wire logic [trace_cfg_pkg::BE_BITS-1:0]     lsu_be_i,
  input  wire logic [trace_cfg_pkg::VLEN-1:0]        lsu_vaddr_i,
  input  wire logic [trace_cfg_pkg::TRANS_ID_BITS-1:0] lsu_trans_id_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]        lsu_wdata_i,
  // Commit probes
  input  wire logic [trace_cfg_pkg::TRANS_ID_BITS-1:0] commit_ptr_i,
  input  wire logic                                  commit_valid_i,
  input  wire logic                                  commit_ack_i,
  input  wire logic                                  ex_valid_i,
  input  wire logic                                  debug_mode_i,
  input  wire trace_isa_pkg::exc_cause_e             ex_cause_i,
  input  wire trace_isa_pkg::priv_lvl_e              priv_lvl_i,
  input  wire logic [trace_cfg_pkg::VLEN-1:0]        commit_pc_i,
  input  wire logic [4:0]                            commit_rs1_i,
  input  wire logic [4:0]                            commit_rs2_i,
  input  wire logic [4:0]                            commit_rd_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]        commit_result_i,
  input  wire logic [trace_cfg_pkg::XLEN-1:0]        commit_wdata_i,
  input  wire logic [trace_cfg_pkg::PLEN-1:0]        mem_paddr_i,
  // Retirement record
  output logic                                       rvfi_valid_o,
  output logic                                       rvfi_trap_o,
  output logic      [31:0]                           rvfi_insn_o,
  output trace_isa_pkg::exc_cause_e                  rvfi_cause_o,
  output logic      [1:0]                            rvfi_mode_o,
  output logic      [1:0]                            rvfi_ixl_o,
  output logic      [4:0]                            rvfi_rs1_addr_o,
  output logic      [4:0]                            rvfi_rs2_addr_o,
  output logic      [4:0]                            rvfi_rd_addr_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]        rvfi_rd_wdata_o,
  output logic      [trace_cfg_pkg::VLEN-1:0]        rvfi_pc_rdata_o,
  output logic      [trace_cfg_pkg::VLEN-1:0]        rvfi_mem_addr_o,
  output logic      [trace_cfg_pkg::PLEN-1:0]        rvfi_mem_paddr_o,
  output logic      [trace_cfg_pkg::BE_BITS-1:0]     rvfi_mem_rmask_o,
  output logic      [trace_cfg_pkg::BE_BITS-1:0]     rvfi_mem_wmask_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]        rvfi_mem_wdata_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]        rvfi_mem_rdata_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]        rvfi_rs1_rdata_o,
  output logic      [trace_cfg_pkg::XLEN-1:0]        rvfi_rs2_rdata_o
);

  import trace_cfg_pkg::*;

  logic [31:0]        issue_instr;
  logic [XLEN-1:0]    sb_rs1_rdata;
  logic [XLEN-1:0]    sb_rs2_rdata;
  logic [VLEN-1:0]    sb_lsu_addr;
  logic [BE_BITS-1:0] sb_lsu_rmask;
  logic [BE_BITS-1:0] sb_lsu_wmask;
  logic [XLEN-1:0]    sb_lsu_wdata;
  logic [31:0]        sb_instr;

  // --------------------------------------------------------------------------
  // Fetch to issue
  // --------------------------------------------------------------------------
  issue_capture i_issue_capture (
    .clk_i,
    .rst_ni,
    .fetch_valid_i,
    .fetch_instr_i,
    .fetch_compressed_i,
    .issue_ack_i,
    .flush_i,
    .issue_instr_o (issue_instr)
  );

  // --------------------------------------------------------------------------
  // Per-transaction shadow state
  // --------------------------------------------------------------------------
  trace_scoreboard i_trace_scoreboard (
    .clk_i,
    .rst_ni,
    .decoded_valid_i,
    .decoded_ack_i,
    .flush_unissued_i,
    .issue_ptr_i,
    .issue_instr_i  (issue_instr),
    .rs1_fwd_i,
    .rs2_fwd_i,
    .lsu_fu_i,
    .lsu_be_i,
    .lsu_vaddr_i,
    .lsu_trans_id_i,
    .lsu_wdata_i,
    .commit_ptr_i,
    .sb_rs1_rdata_o (sb_rs1_rdata),
    .sb_rs2_rdata_o (sb_rs2_rdata),
    .sb_lsu_addr_o  (sb_lsu_addr),
    .sb_lsu_rmask_o (sb_lsu_rmask),
    .sb_lsu_wmask_o (sb_lsu_wmask),
    .sb_lsu_wdata_o (sb_lsu_wdata),
    .sb_instr_o     (sb_instr)
  );

  // --------------------------------------------------------------------------
  // Record packing at commit
  // --------------------------------------------------------------------------
  commit_packer i_commit_packer (
    .commit_valid_i,
    .commit_ack_i,
    .ex_valid_i,
    .debug_mode_i,
    .ex_cause_i,
    .priv_lvl_i,
    .commit_pc_i,
    .commit_rs1_i,
    .commit_rs2_i,
    .commit_rd_i,
    .commit_result_i,
    .commit_wdata_i,
    .mem_paddr_i,
    .sb_rs1_rdata_i (sb_rs1_rdata),
    .sb_rs2_rdata_i (sb_rs2_rdata),
    .sb_lsu_addr_i  (sb_lsu_addr),
    .sb_lsu_rmask_i (sb_lsu_rmask),
    .sb_lsu_wmask_i (sb_lsu_wmask),
    .sb_lsu_wdata_i (sb_lsu_wdata),
    .sb_instr_i     (sb_instr),
    .rvfi_valid_o,
    .rvfi_trap_o,
    .rvfi_insn_o,
    .rvfi_cause_o,
    .rvfi_mode_o,
    .rvfi_ixl_o,
    .rvfi_rs1_addr_o,
    .rvfi_rs2_addr_o,
    .rvfi_rd_addr_o,
    .rvfi_rd_wdata_o,
    .rvfi_pc_rdata_o,
    .rvfi_mem_addr_o,
    .rvfi_mem_paddr_o,
    .rvfi_mem_rmask_o,
    .rvfi_mem_wmask_o,
    .rvfi_mem_wdata_o,
    .rvfi_mem_rdata_o,
    .rvfi_rs1_rdata_o,
    .rvfi_rs2_rdata_o
  );

endmodule

`default_nettype wire

//--- tb_rvfi_checks.svh
`ifndef TB_RVFI_CHECKS_SVH
`define TB_RVFI_CHECKS_SVH

// Expected scoreboard contents, one slot per transaction id
logic [XLEN-1:0]    exp_rs1   [NR_SB_ENTRIES] = '{default: '0};
logic [XLEN-1:0]    exp_rs2   [NR_SB_ENTRIES] = '{default: '0};
logic [31:0]        exp_instr [NR_SB_ENTRIES] = '{default: '0};
logic [VLEN-1:0]    exp_addr  [NR_SB_ENTRIES] = '{default: '0};
logic [BE_BITS-1:0] exp_rmask [NR_SB_ENTRIES] = '{default: '0};
logic [BE_BITS-1:0] exp_wmask [NR_SB_ENTRIES] = '{default: '0};
logic [XLEN-1:0]    exp_wdata [NR_SB_ENTRIES] = '{default: '0};

int checks_run = 0;
int errors     = 0;

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
  checks_run++;
  assert (actual === expected)
  else begin
    errors++;
    $display("FAILED at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
  end
endtask

// Whole retirement record against the model entry and the driven commit probes
task automatic check_record(input logic [TRANS_ID_BITS-1:0] id, input logic exp_valid,
                            input logic exp_trap, input logic [1:0] exp_mode);
  check_value("rvfi_valid_o", 64'(rvfi_valid_o), 64'(exp_valid));
  check_value("rvfi_trap_o", 64'(rvfi_trap_o), 64'(exp_trap));
  check_value("rvfi_insn_o", 64'(rvfi_insn_o), 64'(exp_instr[id]));
  check_value("rvfi_cause_o", 64'(rvfi_cause_o), 64'(ex_cause_i));
  check_value("rvfi_mode_o", 64'(rvfi_mode_o), 64'(exp_mode));
  check_value("rvfi_ixl_o", 64'(rvfi_ixl_o), 64'(2'd1));  // RV32
  check_value("rvfi_rs1_addr_o", 64'(rvfi_rs1_addr_o), 64'(commit_rs1_i));
  check_value("rvfi_rs2_addr_o", 64'(rvfi_rs2_addr_o), 64'(commit_rs2_i));
  check_value("rvfi_rd_addr_o", 64'(rvfi_rd_addr_o), 64'(commit_rd_i));
  check_value("rvfi_rd_wdata_o", 64'(rvfi_rd_wdata_o), 64'(commit_wdata_i));
  check_value("rvfi_pc_rdata_o", 64'(rvfi_pc_rdata_o), 64'(commit_pc_i));
  check_value("rvfi_rs1_rdata_o", 64'(rvfi_rs1_rdata_o), 64'(exp_rs1[id]));
  check_value("rvfi_rs2_rdata_o", 64'(rvfi_rs2_rdata_o), 64'(exp_rs2[id]));
  // Memory fields
  check_value("rvfi_mem_addr_o", 64'(rvfi_mem_addr_o), 64'(exp_addr[id]));
  check_value("rvfi_mem_paddr_o", 64'(rvfi_mem_paddr_o), 64'(mem_paddr_i));
  check_value("rvfi_mem_rmask_o", 64'(rvfi_mem_rmask_o), 64'(exp_rmask[id]));
  check_value("rvfi_mem_wmask_o", 64'(rvfi_mem_wmask_o), 64'(exp_wmask[id]));
  check_value("rvfi_mem_wdata_o", 64'(rvfi_mem_wdata_o), 64'(exp_wdata[id]));
  check_value("rvfi_mem_rdata_o", 64'(rvfi_mem_rdata_o), 64'(commit_result_i));
endtask

task automatic report_results();
  $display("Checks run: %0d, errors: %0d", checks_run, errors);
  if (errors == 0) begin
    $display("Everything OK");
  end else begin
    $display("Something failed");
  end
endtask

`endif

//--- tb_rvfi_trace.sv
`default_nettype none

module tb_rvfi_trace;

  import trace_cfg_pkg::*;
  import trace_isa_pkg::*;

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 8;
  localparam int NUM_SCENARIOS = 6;
  localparam int TIMEOUT       = (RESET_CYCLES + NUM_SCENARIOS * 20) * CLK_PERIOD;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     fetch_valid_i, fetch_compressed_i, issue_ack_i, flush_i;
  logic [31:0]              fetch_instr_i;
  logic                     decoded_valid_i, decoded_ack_i, flush_unissued_i;
  logic [TRANS_ID_BITS-1:0] issue_ptr_i, lsu_trans_id_i, commit_ptr_i;
  logic [XLEN-1:0]          rs1_fwd_i, rs2_fwd_i, lsu_wdata_i;
  fu_e                      lsu_fu_i;
  logic [BE_BITS-1:0]       lsu_be_i;
  logic [VLEN-1:0]          lsu_vaddr_i, commit_pc_i;
  logic                     commit_valid_i, commit_ack_i, ex_valid_i, debug_mode_i;
  exc_cause_e               ex_cause_i;
  priv_lvl_e                priv_lvl_i;
  logic [4:0]               commit_rs1_i, commit_rs2_i, commit_rd_i;
  logic [XLEN-1:0]          commit_result_i, commit_wdata_i;
  logic [PLEN-1:0]          mem_paddr_i;

  logic                     rvfi_valid_o, rvfi_trap_o;
  logic [31:0]              rvfi_insn_o;
  exc_cause_e               rvfi_cause_o;
  logic [1:0]               rvfi_mode_o, rvfi_ixl_o;
  logic [4:0]               rvfi_rs1_addr_o, rvfi_rs2_addr_o, rvfi_rd_addr_o;
  logic [XLEN-1:0]          rvfi_rd_wdata_o, rvfi_mem_wdata_o, rvfi_mem_rdata_o;
  logic [XLEN-1:0]          rvfi_rs1_rdata_o, rvfi_rs2_rdata_o;
  logic [VLEN-1:0]          rvfi_pc_rdata_o, rvfi_mem_addr_o;
  logic [PLEN-1:0]          rvfi_mem_paddr_o;
  logic [BE_BITS-1:0]       rvfi_mem_rmask_o, rvfi_mem_wmask_o;

  integer      seed = 32'he5f4;
  logic        held_valid = 1'b0;  // Model of the fetch holding register
  logic [31:0] held_word  = '0;

  `include "tb_rvfi_checks.svh"

  rvfi_trace i_rvfi_trace (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
    $display("Something failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Probe drivers, all on the falling edge
  // --------------------------------------------------------------------------
  task automatic clear_inputs();
    {fetch_valid_i, fetch_compressed_i, issue_ack_i, flush_i} = '0;
    fetch_instr_i = '0;
    {decoded_valid_i, decoded_ack_i, flush_unissued_i} = '0;
    {issue_ptr_i, lsu_trans_id_i, commit_ptr_i} = '0;
    {rs1_fwd_i, rs2_fwd_i, lsu_wdata_i} = '0;
    lsu_fu_i = FU_NONE;
    lsu_be_i = '0;
    {lsu_vaddr_i, commit_pc_i} = '0;
    {commit_valid_i, commit_ack_i, ex_valid_i, debug_mode_i} = '0;
    ex_cause_i = EXC_BREAKPOINT;
    priv_lvl_i = PRIV_M;
    {commit_rs1_i, commit_rs2_i, commit_rd_i} = '0;
    {commit_result_i, commit_wdata_i} = '0;
    mem_paddr_i = '0;
  endtask

  task automatic fetch_word(input logic [31:0] word, input logic compressed);
    @(negedge clk_i);
    fetch_valid_i      = 1'b1;
    fetch_instr_i      = word;
    fetch_compressed_i = compressed;
    if (!held_valid) begin  // A full register ignores the fetch
      held_word  = compressed ? {16'h0000, word[15:0]} : word;
      held_valid = 1'b1;
    end
    @(negedge clk_i);
    fetch_valid_i = 1'b0;
  endtask

  task automatic flush_fetch();
    @(negedge clk_i);
    flush_i    = 1'b1;
    held_valid = 1'b0;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  task automatic issue_to(input logic [TRANS_ID_BITS-1:0] id, input logic discard);
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    rs1 = $random(seed);
    rs2 = $random(seed);
    @(negedge clk_i);
    {decoded_valid_i, decoded_ack_i, issue_ack_i} = 3'b111;
    flush_unissued_i = discard;
    issue_ptr_i      = id;
    rs1_fwd_i        = rs1;
    rs2_fwd_i        = rs2;
    if (!discard) begin
      exp_rs1[id]   = rs1;
      exp_rs2[id]   = rs2;
      exp_instr[id] = held_word;
      exp_addr[id]  = '0;
      exp_rmask[id] = '0;
      exp_wmask[id] = '0;
      exp_wdata[id] = '0;
    end
    held_valid = 1'b0;  // Acked either way
    @(negedge clk_i);
    {decoded_valid_i, decoded_ack_i, issue_ack_i, flush_unissued_i} = '0;
  endtask

  task automatic lsu_access(input logic [TRANS_ID_BITS-1:0] id, input fu_e fu,
                            input logic [BE_BITS-1:0] be);
    logic [VLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    addr  = $random(seed);
    wdata = $random(seed);
    @(negedge clk_i);
    lsu_fu_i       = fu;
    lsu_be_i       = be;
    lsu_vaddr_i    = addr;
    lsu_trans_id_i = id;
    lsu_wdata_i    = wdata;
    if (fu == FU_LOAD && be != '0) begin
      exp_addr[id]  = addr;
      exp_rmask[id] = be;
    end else if (fu == FU_STORE && be != '0) begin
      exp_addr[id]  = addr;
      exp_wmask[id] = be;
      exp_wdata[id] = wdata;
    end
    @(negedge clk_i);
    lsu_fu_i = FU_NONE;
    lsu_be_i = '0;
  endtask

  task automatic commit_check(input logic [TRANS_ID_BITS-1:0] id, input logic ex,
                              input exc_cause_e cause, input priv_lvl_e priv,
                              input logic debug);
    logic       env_call;
    logic       exp_valid;
    logic [1:0] exp_mode;
    env_call  = cause inside {EXC_ECALL_U, EXC_ECALL_S, EXC_ECALL_M};
    exp_valid = ex ? env_call : 1'b1;  // Ecalls retire, other traps do not
    exp_mode  = debug ? MODE_DEBUG : priv;
    @(negedge clk_i);
    commit_ptr_i    = id;
    commit_valid_i  = 1'b1;
    commit_ack_i    = !ex;
    ex_valid_i      = ex;
    ex_cause_i      = cause;
    priv_lvl_i      = priv;
    debug_mode_i    = debug;
    commit_pc_i     = $random(seed);
    commit_rs1_i    = 5'($random(seed));
    commit_rs2_i    = 5'($random(seed));
    commit_rd_i     = 5'($random(seed));
    commit_result_i = $random(seed);
    commit_wdata_i  = $random(seed);
    mem_paddr_i     = {2'($random(seed)), 32'($random(seed))};
    #(CLK_PERIOD / 4);  // Record is combinational, sample mid low phase
    check_record(id, exp_valid, ex, exp_mode);
    @(negedge clk_i);
    {commit_valid_i, commit_ack_i, ex_valid_i, debug_mode_i} = '0;
  endtask

  // --------------------------------------------------------------------------
  // Scenario sequence
  // --------------------------------------------------------------------------
  initial begin
    clear_inputs();
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #(CLK_PERIOD / 4);
    check_value("rvfi_valid_o", 64'(rvfi_valid_o), 64'(1'b0));
    check_value("rvfi_insn_o", 64'(rvfi_insn_o), 64'(32'h0));

    // Compressed and full-width words
    fetch_word(32'hABCD_4501, 1'b1);
    issue_to(3'd0, 1'b0);
    commit_check(3'd0, 1'b0, EXC_BREAKPOINT, PRIV_M, 1'b0);
    fetch_word(32'h0083_2183, 1'b0);
    issue_to(3'd1, 1'b0);
    commit_check(3'd1, 1'b0, EXC_BREAKPOINT, PRIV_M, 1'b0);

    // Four in flight, retired out of issue order
    for (int i = 2; i < 6; i++) begin
      fetch_word($random(seed), 1'b0);
      issue_to(3'(i), 1'b0);
    end
    commit_check(3'd4, 1'b0, EXC_BREAKPOINT, PRIV_M, 1'b0);
    commit_check(3'd2, 1'b0, EXC_BREAKPOINT, PRIV_S, 1'b0);
    commit_check(3'd5, 1'b0, EXC_BREAKPOINT, PRIV_U, 1'b0);
    commit_check(3'd3, 1'b0, EXC_BREAKPOINT, PRIV_M, 1'b0);

    // Load then store
    fetch_word(32'h0004_A303, 1'b0);
    issue_to(3'd6, 1'b0);
    lsu_access(3'd6, FU_LOAD, 4'b0011);
    commit_check(3'd6, 1'b0, EXC_BREAKPOINT, PRIV_M, 1'b0);
    fetch_word(32'h0065_A023, 1'b0);
    issue_to(3'd7, 1'b0);
    lsu_access(3'd7, FU_STORE, 4'b1111);
    commit_check(3'd7, 1'b0, EXC_BREAKPOINT, PRIV_M, 1'b0);

    // Traps
    commit_check(3'd0, 1'b1, EXC_ECALL_M, PRIV_M, 1'b0);
    commit_check(3'd0, 1'b1, EXC_ILLEGAL_INSTR, PRIV_M, 1'b0);
    commit_check(3'd1, 1'b0, EXC_ILLEGAL_INSTR, PRIV_U, 1'b0);

    // Debug mode overrides privilege
    commit_check(3'd1, 1'b0, EXC_BREAKPOINT, PRIV_U, 1'b1);
    commit_check(3'd1, 1'b0, EXC_BREAKPOINT, PRIV_S, 1'b0);
    commit_check(3'd1, 1'b1, EXC_ECALL_S, PRIV_M, 1'b1);

    // Flushed issue leaves the old entry, flushed fetch loses its word
    fetch_word(32'h0000_0013, 1'b0);
    issue_to(3'd2, 1'b1);
    commit_check(3'd2, 1'b0, EXC_BREAKPOINT, PRIV_M, 1'b0);
    fetch_word(32'h1111_1113, 1'b0);
    flush_fetch();
    fetch_word(32'h2222_2213, 1'b0);
    issue_to(3'd3, 1'b0);
    commit_check(3'd3, 1'b0, EXC_BREAKPOINT, PRIV_M, 1'b0);

    report_results();
    $finish;
  end

endmodule

`default_nettype wire

//--- rvfi_trace.f
+incdir+.
trace_cfg_pkg.sv
trace_isa_pkg.sv
issue_capture.sv
trace_scoreboard.sv
commit_packer.sv
rvfi_trace.sv
tb_rvfi_trace.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for a failure

LOG=sim.log

rm -f "$LOG"
verilator --binary --timing --assert -f rvfi_trace.f --top-module tb_rvfi_trace \
  && ./obj_dir/Vtb_rvfi_trace > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "Something failed" "$LOG" \
  && { echo "Simulation reported errors"; exit 1; } \
  || { echo "Simulation clean"; exit 0; }
